// ==== source/c2a_pkg.sv ====
// ======================================================================
// core-to-AXI bridge package: bus widths, response codes, FSM states
// and the register map of the error/status block
// ======================================================================
package c2a_pkg;

  // bus widths
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned AxiDataWidth  = 64;
  localparam int unsigned AxiStrbWidth  = AxiDataWidth / 8;
  localparam int unsigned CoreDataWidth = 32;
  localparam int unsigned ProtWidth     = 3;

  // saturating error counter
  localparam int unsigned ErrCountWidth = 16;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespExOkay = 2'b01;
  localparam logic [1:0] RespSlvErr = 2'b10;
  localparam logic [1:0] RespDecErr = 2'b11;

  typedef enum logic [2:0] {
    IDLE,
    READ_WAIT,
    WRITE_DATA,
    WRITE_ADDR,
    WRITE_WAIT
  } bridge_state_e;

  // word index on the configuration port, word 3 reads as zero
  typedef enum logic [1:0] {
    REG_ERR_COUNT = 2'd0,
    REG_ERR_ADDR  = 2'd1,
    REG_CTRL      = 2'd2
  } err_reg_e;

  // SLVERR and DECERR count as errors
  function automatic logic resp_is_err(input logic [1:0] resp);
    logic is_err;
    case (resp)
      RespOkay, RespExOkay: is_err = 1'b0;
      RespSlvErr, RespDecErr: is_err = 1'b1;
      default: is_err = 1'b0;
    endcase
    return is_err;
  endfunction

endpackage

// ==== source/core2axi_bridge.sv ====
// ======================================================================
// core data port to AXI4 bridge, one single-beat access in flight,
// 32-bit core data mapped onto a 64-bit AXI data bus
// ======================================================================
`timescale 1ns/1ps

module core2axi_bridge import c2a_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // core data port
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  logic [AddrWidth-1:0]       data_addr_i,
  input  logic [CoreDataWidth/8-1:0] data_be_i,
  input  logic [CoreDataWidth-1:0]   data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [CoreDataWidth-1:0]   data_rdata_o,

  // protection bits from the register block
  input  logic [ProtWidth-1:0]       axi_prot_i,

  // AW channel
  output logic [AddrWidth-1:0]       aw_addr_o,
  output logic [ProtWidth-1:0]       aw_prot_o,
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,

  // W channel
  output logic [AxiDataWidth-1:0]    w_data_o,
  output logic [AxiStrbWidth-1:0]    w_strb_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,

  // B channel
  input  logic [1:0]                 b_resp_i,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,

  // AR channel
  output logic [AddrWidth-1:0]       ar_addr_o,
  output logic [ProtWidth-1:0]       ar_prot_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,

  // R channel
  input  logic [AxiDataWidth-1:0]    r_data_i,
  input  logic [1:0]                 r_resp_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,

  // error report to the register block
  output logic                       err_pulse_o,
  output logic [AddrWidth-1:0]       err_addr_o
);

  localparam int unsigned CoreStrbWidth = CoreDataWidth / 8;
  localparam int unsigned LaneCount     = AxiDataWidth / CoreDataWidth;

  bridge_state_e state_q, state_d;

  // address of the access in flight, captured at grant
  logic [AddrWidth-1:0] addr_q;

  // main FSM
  always_comb begin
    state_d       = state_q;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    err_pulse_o   = 1'b0;
    aw_valid_o    = 1'b0;
    w_valid_o     = 1'b0;
    b_ready_o     = 1'b0;
    ar_valid_o    = 1'b0;
    r_ready_o     = 1'b0;

    case (state_q)
      IDLE: begin
        if (data_req_i) begin
          if (data_we_i) begin
            // address and data are offered together
            aw_valid_o = 1'b1;
            w_valid_o  = 1'b1;
            case ({aw_ready_i, w_ready_i})
              2'b11: begin
                data_gnt_o = 1'b1;
                state_d    = WRITE_WAIT;
              end
              2'b10: begin
                state_d = WRITE_DATA;
              end
              2'b01: begin
                state_d = WRITE_ADDR;
              end
              default: begin
                state_d = IDLE;
              end
            endcase
          end else begin
            ar_valid_o = 1'b1;
            if (ar_ready_i) begin
              data_gnt_o = 1'b1;
              state_d    = READ_WAIT;
            end
          end
        end
      end

      // address taken, data still pending
      WRITE_DATA: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          data_gnt_o = 1'b1;
          state_d    = WRITE_WAIT;
        end
      end

      // data taken, address still pending
      WRITE_ADDR: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          data_gnt_o = 1'b1;
          state_d    = WRITE_WAIT;
        end
      end

      WRITE_WAIT: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          data_rvalid_o = 1'b1;
          err_pulse_o   = resp_is_err(b_resp_i);
          state_d       = IDLE;
        end
      end

      READ_WAIT: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          data_rvalid_o = 1'b1;
          err_pulse_o   = resp_is_err(r_resp_i);
          state_d       = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the core holds the address stable until grant
  always_ff @(posedge clk_i) begin
    if (data_gnt_o) begin
      addr_q <= data_addr_i;
    end
  end

  // addresses and protection go straight through
  assign aw_addr_o = data_addr_i;
  assign ar_addr_o = data_addr_i;
  assign aw_prot_o = axi_prot_i;
  assign ar_prot_o = axi_prot_i;

  // write data replicated on both lanes, strobes pick the lane
  assign w_data_o = {LaneCount{data_wdata_i}};
  assign w_strb_o = data_addr_i[2] ? {data_be_i, {CoreStrbWidth{1'b0}}}
                                   : {{CoreStrbWidth{1'b0}}, data_be_i};

  // read lane selected by the address of the granted access
  assign data_rdata_o = addr_q[2] ? r_data_i[CoreDataWidth +: CoreDataWidth]
                                  : r_data_i[0 +: CoreDataWidth];

  assign err_addr_o = addr_q;

endmodule

// ==== source/c2a_err_regs.sv ====
// ======================================================================
// error and status registers: saturating error count, last error
// address, control register with AXI prot bits and interrupt enable
// ======================================================================
`timescale 1ns/1ps

module c2a_err_regs import c2a_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // configuration port
  input  logic                     cfg_req_i,
  input  logic                     cfg_we_i,
  input  logic [1:0]               cfg_addr_i,
  input  logic [CoreDataWidth-1:0] cfg_wdata_i,
  output logic [CoreDataWidth-1:0] cfg_rdata_o,

  // error report from the bridge
  input  logic                     err_pulse_i,
  input  logic [AddrWidth-1:0]     err_addr_i,

  output logic [ProtWidth-1:0]     axi_prot_o,
  output logic                     irq_o
);

  err_reg_e                 reg_sel;
  logic                     clr_count;
  logic                     ctrl_we;
  logic                     count_max;
  logic [ErrCountWidth-1:0] count_q;
  logic [AddrWidth-1:0]     err_addr_q;
  logic [ProtWidth-1:0]     prot_q;
  logic                     irq_en_q;
  logic                     irq_q;
  logic [CoreDataWidth-1:0] rdata_d;
  logic [CoreDataWidth-1:0] rdata_q;

  assign reg_sel   = err_reg_e'(cfg_addr_i);
  assign clr_count = cfg_req_i && cfg_we_i && (reg_sel == REG_ERR_COUNT);
  assign ctrl_we   = cfg_req_i && cfg_we_i && (reg_sel == REG_CTRL);
  assign count_max = &count_q;

  // read mux, unmapped word reads zero
  always_comb begin
    rdata_d = '0;
    case (reg_sel)
      REG_ERR_COUNT: rdata_d[ErrCountWidth-1:0] = count_q;
      REG_ERR_ADDR:  rdata_d[AddrWidth-1:0]     = err_addr_q;
      REG_CTRL:      rdata_d[ProtWidth:0]       = {irq_en_q, prot_q};
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q    <= '0;
      err_addr_q <= '0;
      prot_q     <= '0;
      irq_en_q   <= 1'b0;
      irq_q      <= 1'b0;
      rdata_q    <= '0;
    end else begin
      // a clear coinciding with an error leaves that error counted
      if (clr_count) begin
        count_q <= err_pulse_i ? ErrCountWidth'(1) : '0;
      end else if (err_pulse_i && !count_max) begin
        count_q <= count_q + 1'b1;
      end

      if (err_pulse_i) begin
        err_addr_q <= err_addr_i;
      end

      if (ctrl_we) begin
        prot_q   <= cfg_wdata_i[ProtWidth-1:0];
        irq_en_q <= cfg_wdata_i[ProtWidth];
      end

      irq_q <= irq_en_q && (count_q != '0);

      if (cfg_req_i && !cfg_we_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign cfg_rdata_o = rdata_q;
  assign axi_prot_o  = prot_q;
  assign irq_o       = irq_q;

endmodule

// ==== source/core2axi_top.sv ====
// ======================================================================
// core-to-AXI bridge top level with the error and status registers
// ======================================================================
`timescale 1ns/1ps

module core2axi_top import c2a_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // core data port
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  logic [AddrWidth-1:0]       data_addr_i,
  input  logic [CoreDataWidth/8-1:0] data_be_i,
  input  logic [CoreDataWidth-1:0]   data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [CoreDataWidth-1:0]   data_rdata_o,

  // configuration port
  input  logic                       cfg_req_i,
  input  logic                       cfg_we_i,
  input  logic [1:0]                 cfg_addr_i,
  input  logic [CoreDataWidth-1:0]   cfg_wdata_i,
  output logic [CoreDataWidth-1:0]   cfg_rdata_o,

  // AXI master
  output logic [AddrWidth-1:0]       aw_addr_o,
  output logic [ProtWidth-1:0]       aw_prot_o,
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output logic [AxiDataWidth-1:0]    w_data_o,
  output logic [AxiStrbWidth-1:0]    w_strb_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  input  logic [1:0]                 b_resp_i,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  output logic [AddrWidth-1:0]       ar_addr_o,
  output logic [ProtWidth-1:0]       ar_prot_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  input  logic [AxiDataWidth-1:0]    r_data_i,
  input  logic [1:0]                 r_resp_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,

  output logic                       irq_o
);

  logic                 err_pulse;
  logic [AddrWidth-1:0] err_addr;
  logic [ProtWidth-1:0] axi_prot;

  core2axi_bridge i_bridge (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_addr_i   (data_addr_i),
    .data_be_i     (data_be_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .axi_prot_i    (axi_prot),
    .aw_addr_o     (aw_addr_o),
    .aw_prot_o     (aw_prot_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .w_data_o      (w_data_o),
    .w_strb_o      (w_strb_o),
    .w_valid_o     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .b_resp_i      (b_resp_i),
    .b_valid_i     (b_valid_i),
    .b_ready_o     (b_ready_o),
    .ar_addr_o     (ar_addr_o),
    .ar_prot_o     (ar_prot_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_data_i      (r_data_i),
    .r_resp_i      (r_resp_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .err_pulse_o   (err_pulse),
    .err_addr_o    (err_addr)
  );

  // the register block also steers the prot bits of the bridge
  c2a_err_regs i_err_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .err_pulse_i (err_pulse),
    .err_addr_i  (err_addr),
    .axi_prot_o  (axi_prot),
    .irq_o       (irq_o)
  );

endmodule

// ==== sim/tb_axi_mem.sv ====
// ======================================================================
// AXI4 memory model for the testbench: 4 KiB, random ready and valid
// delays, DECERR for every address above the memory
// ======================================================================
`timescale 1ns/1ps

module tb_axi_mem import c2a_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // fresh random bits every cycle
  input  logic [31:0]             rnd_i,
  input  logic [AddrWidth-1:0]    aw_addr_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  logic [AxiDataWidth-1:0] w_data_i,
  input  logic [AxiStrbWidth-1:0] w_strb_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output logic [1:0]              b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  input  logic [AddrWidth-1:0]    ar_addr_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output logic [AxiDataWidth-1:0] r_data_o,
  output logic [1:0]              r_resp_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i
);

  localparam int unsigned MemBytes = 4096;

  logic [7:0]              mem [MemBytes];
  logic [AddrWidth-1:0]    aw_addr_q, ar_addr_q;
  logic [AxiDataWidth-1:0] w_data_q;
  logic [AxiStrbWidth-1:0] w_strb_q;
  logic                    aw_have, w_have, b_pend, r_pend;
  logic [1:0]              aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt;

  // initial content, every byte depends on its full address
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'((a * 37) ^ (a >> 5));
  endfunction

  function automatic logic [AxiDataWidth-1:0] read_beat(input logic [AddrWidth-1:0] addr);
    logic [AxiDataWidth-1:0] beat;
    for (int i = 0; i < AxiStrbWidth; i++) begin
      beat[8*i +: 8] = mem[{addr[11:3], 3'b000} + i];
    end
    return beat;
  endfunction

  initial begin
    for (int a = 0; a < MemBytes; a++) begin
      mem[a] = fill_byte(a);
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
      b_resp_o   <= RespOkay;
      r_resp_o   <= RespOkay;
      r_data_o   <= '0;
      aw_have    <= 1'b0;
      w_have     <= 1'b0;
      b_pend     <= 1'b0;
      r_pend     <= 1'b0;
      {aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt} <= '0;
    end else begin
      // AW and W are taken independently, ready comes 1 to 4 cycles after valid
      if (aw_valid_i && aw_ready_o) begin
        aw_ready_o <= 1'b0;
        aw_have    <= 1'b1;
        aw_addr_q  <= aw_addr_i;
        aw_cnt     <= rnd_i[1:0];
      end else if (aw_valid_i && !aw_have) begin
        if (aw_cnt == 0) aw_ready_o <= 1'b1;
        else aw_cnt <= aw_cnt - 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
        w_ready_o <= 1'b0;
        w_have    <= 1'b1;
        w_data_q  <= w_data_i;
        w_strb_q  <= w_strb_i;
        w_cnt     <= rnd_i[3:2];
      end else if (w_valid_i && !w_have) begin
        if (w_cnt == 0) w_ready_o <= 1'b1;
        else w_cnt <= w_cnt - 1'b1;
      end

      // both halves present, commit the write and start the response
      if (aw_have && w_have && !b_pend) begin
        for (int i = 0; i < AxiStrbWidth; i++) begin
          if (w_strb_q[i] && aw_addr_q < MemBytes) begin
            mem[{aw_addr_q[11:3], 3'b000} + i] <= w_data_q[8*i +: 8];
          end
        end
        aw_have  <= 1'b0;
        w_have   <= 1'b0;
        b_pend   <= 1'b1;
        b_cnt    <= rnd_i[7:6];
        b_resp_o <= (aw_addr_q < MemBytes) ? RespOkay : RespDecErr;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        b_pend    <= 1'b0;
      end else if (b_pend && !b_valid_o) begin
        if (b_cnt == 0) b_valid_o <= 1'b1;
        else b_cnt <= b_cnt - 1'b1;
      end

      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        ar_addr_q  <= ar_addr_i;
        r_pend     <= 1'b1;
        r_cnt      <= rnd_i[9:8];
        ar_cnt     <= rnd_i[5:4];
      end else if (ar_valid_i && !r_pend) begin
        if (ar_cnt == 0) ar_ready_o <= 1'b1;
        else ar_cnt <= ar_cnt - 1'b1;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        r_pend    <= 1'b0;
      end else if (r_pend && !r_valid_o) begin
        if (r_cnt == 0) begin
          r_valid_o <= 1'b1;
          r_data_o  <= (ar_addr_q < MemBytes) ? read_beat(ar_addr_q) : '0;
          r_resp_o  <= (ar_addr_q < MemBytes) ? RespOkay : RespDecErr;
        end else begin
          r_cnt <= r_cnt - 1'b1;
        end
      end
    end
  end

endmodule

// ==== sim/tb_top.sv ====
// ======================================================================
// testbench for the core-to-AXI bridge with core and config stimulus,
// a byte mirror of the memory and checks of error registers and prot
// ======================================================================
`timescale 1ns/1ps

module tb_top import c2a_pkg::*; ();

  logic                     clk_i, rst_ni;
  logic                     data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
  logic [AddrWidth-1:0]     data_addr_i, aw_addr_o, ar_addr_o;
  logic [3:0]               data_be_i;
  logic [CoreDataWidth-1:0] data_wdata_i, data_rdata_o, cfg_wdata_i, cfg_rdata_o;
  logic                     cfg_req_i, cfg_we_i, irq_o;
  logic [1:0]               cfg_addr_i, b_resp_i, r_resp_i;
  logic [ProtWidth-1:0]     aw_prot_o, ar_prot_o;
  logic                     aw_valid_o, aw_ready_i, w_valid_o, w_ready_i;
  logic                     b_valid_i, b_ready_o, ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
  logic [AxiDataWidth-1:0]  w_data_o, r_data_i;
  logic [AxiStrbWidth-1:0]  w_strb_o;

  logic [31:0] stim_rnd, mem_rnd;
  logic [7:0]  mirror [4096];
  // bit 32 set when the read data is to be compared
  logic [32:0] exp_q [$];
  logic [32:0] exp_entry;
  logic [2:0]  prot_exp;
  logic        prot_check, aw_seen, w_seen;
  int          errors, checks, tests_run, tests_failed, err_mark;
  int          gnt_cnt, rvalid_cnt, n_aw_first, n_w_first, n_both;

  core2axi_top i_dut (.*);

  tb_axi_mem i_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rnd_i      (mem_rnd),
    .aw_addr_i  (aw_addr_o),
    .aw_valid_i (aw_valid_o),
    .aw_ready_o (aw_ready_i),
    .w_data_i   (w_data_o),
    .w_strb_i   (w_strb_o),
    .w_valid_i  (w_valid_o),
    .w_ready_o  (w_ready_i),
    .b_resp_o   (b_resp_i),
    .b_valid_o  (b_valid_i),
    .b_ready_i  (b_ready_o),
    .ar_addr_i  (ar_addr_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready_i),
    .r_data_o   (r_data_i),
    .r_resp_o   (r_resp_i),
    .r_valid_o  (r_valid_i),
    .r_ready_i  (r_ready_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] draw_rand();
    stim_rnd = next_rand(stim_rnd);
    return stim_rnd;
  endfunction

  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'((a * 37) ^ (a >> 5));
  endfunction

  // reference for the aligned 32-bit word after all earlier writes
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [11:0] base;
    base = {addr[11:2], 2'b00};
    return {mirror[base + 3], mirror[base + 2], mirror[base + 1], mirror[base]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic core_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
    int   waited;
    logic granted;
    if (we && addr < 32'h1000) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mirror[{addr[11:2], 2'b00} + i] = wdata[8*i +: 8];
      end
    end
    exp_q.push_back({!we && addr < 32'h1000, expected_word(addr)});
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_be_i    = be;
    data_wdata_i = wdata;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!data_gnt_o && waited < 100);
    granted = data_gnt_o;
    assert (granted) else begin
      errors++;
      $display("timeout at %0t: no grant for the access to %h", $time, addr);
      void'(exp_q.pop_back());
    end
    #1;
    data_req_i = 1'b0;
    if (granted) begin
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!data_rvalid_o && waited < 100);
      assert (data_rvalid_o) else begin
        errors++;
        $display("timeout at %0t: no rvalid for the access to %h", $time, addr);
      end
      #1;
    end
  endtask

  task automatic random_access();
    logic [31:0] r;
    r = draw_rand();
    core_access(r[31], {20'h0, r[11:2], 2'b00}, r[15:12], draw_rand());
  endtask

  // config requests are taken at once and read data follows one cycle later
  task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
    cfg_req_i   = 1'b1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_req_i = 1'b0;
    cfg_we_i  = 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
    cfg_req_i  = 1'b1;
    cfg_we_i   = 1'b0;
    cfg_addr_i = addr;
    @(posedge clk_i);
    #1;
    cfg_req_i = 1'b0;
    data      = cfg_rdata_o;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  always @(posedge clk_i) begin
    #1;
    mem_rnd = next_rand(mem_rnd);
  end

  // response checker with one expected entry per request
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (data_gnt_o) gnt_cnt++;
      if (data_rvalid_o) begin
        rvalid_cnt++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("rvalid at %0t without a pending request", $time);
        end
        if (exp_q.size() != 0) begin
          exp_entry = exp_q.pop_front();
          if (exp_entry[32]) check_value("read data", data_rdata_o, exp_entry[31:0]);
        end
      end
    end
  end

  // prot bits and order of the AW and W handshakes
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (prot_check && aw_valid_o) check_value("aw_prot", 32'(aw_prot_o), 32'(prot_exp));
      if (prot_check && ar_valid_o) check_value("ar_prot", 32'(ar_prot_o), 32'(prot_exp));
      if (aw_valid_o && aw_ready_i && w_valid_o && w_ready_i) begin
        n_both++;
      end else if (aw_valid_o && aw_ready_i) begin
        if (w_seen) n_w_first++;
        aw_seen = !w_seen;
        w_seen  = 1'b0;
      end else if (w_valid_o && w_ready_i) begin
        if (aw_seen) n_aw_first++;
        w_seen  = !aw_seen;
        aw_seen = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r, rd, last_err;
    int          g0, v0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {data_req_i, data_we_i, data_addr_i, data_be_i, data_wdata_i} = '0;
    {cfg_req_i, cfg_we_i, cfg_addr_i, cfg_wdata_i} = '0;
    {prot_check, prot_exp, aw_seen, w_seen} = '0;
    stim_rnd = 32'd22;
    mem_rnd  = next_rand(32'd22);
    for (int a = 0; a < 4096; a++) begin
      mirror[a] = fill_byte(a);
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < 16; i++) begin
      r = draw_rand();
      core_access(1'b0, {20'h0, r[11:3], i[0], 2'b00}, 4'h0, 32'h0);
    end
    end_test("lane reads");

    // small window so that writes overlap
    for (int i = 0; i < 40; i++) begin
      r = draw_rand();
      core_access(1'b1, {24'h0, r[7:2], 2'b00}, r[11:8], draw_rand());
      core_access(1'b0, {24'h0, r[7:2], 2'b00}, 4'h0, 32'h0);
    end
    for (int i = 0; i < 64; i++) begin
      core_access(1'b0, 32'(i * 4), 4'h0, 32'h0);
    end
    end_test("byte enables");

    {n_aw_first, n_w_first, n_both} = '0;
    g0 = gnt_cnt;
    v0 = rvalid_cnt;
    for (int i = 0; i < 80; i++) begin
      random_access();
      repeat (draw_rand() % 3) begin
        @(posedge clk_i);
        #1;
      end
    end
    check_value("grant count", 32'(gnt_cnt - g0), 32'd80);
    check_value("rvalid count", 32'(rvalid_cnt - v0), 32'd80);
    assert (n_aw_first > 0 && n_w_first > 0 && n_both > 0) else begin
      errors++;
      $display("handshake orders not all seen: aw first %0d, w first %0d, together %0d",
               n_aw_first, n_w_first, n_both);
    end
    end_test("back-pressure");

    // only OKAY responses so far, so nothing may have been counted
    cfg_read(REG_ERR_COUNT, rd);
    check_value("error count before", rd, 32'd0);
    cfg_write(REG_CTRL, 32'h8);
    for (int i = 0; i < 5; i++) begin
      r = draw_rand();
      last_err = 32'h1000 + {r[15:2], 2'b00};
      core_access(r[31], last_err, 4'hf, r);
    end
    cfg_read(REG_ERR_COUNT, rd);
    check_value("error count", rd, 32'd5);
    cfg_read(REG_ERR_ADDR, rd);
    check_value("error address", rd, last_err);
    check_value("irq with errors", 32'(irq_o), 32'd1);
    cfg_write(REG_ERR_COUNT, 32'h0);
    repeat (2) @(posedge clk_i);
    #1;
    check_value("irq after clear", 32'(irq_o), 32'd0);
    cfg_read(REG_ERR_COUNT, rd);
    check_value("cleared count", rd, 32'd0);
    end_test("error logging");

    cfg_write(REG_CTRL, 32'h5);
    prot_exp   = 3'd5;
    prot_check = 1'b1;
    cfg_read(REG_CTRL, rd);
    check_value("ctrl register", rd, 32'h5);
    repeat (20) random_access();
    cfg_write(REG_CTRL, 32'h2);
    prot_exp = 3'd2;
    repeat (20) random_access();
    prot_check = 1'b0;
    check_value("pending requests", 32'(exp_q.size()), 32'd0);
    end_test("prot bits");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
source/c2a_pkg.sv
source/core2axi_bridge.sv
source/c2a_err_regs.sv
source/core2axi_top.sv
sim/tb_axi_mem.sv
sim/tb_top.sv

// ==== Bender.yml ====
package:
  name: core2axi

sources:
  - source/c2a_pkg.sv
  - source/core2axi_bridge.sv
  - source/c2a_err_regs.sv
  - source/core2axi_top.sv
  - target: simulation
    files:
      - sim/tb_axi_mem.sv
      - sim/tb_top.sv
